// File: memArb.f
+incdir+rtl
rtl/memBusPkg.sv
rtl/sigTablePkg.sv
rtl/sigAddrGen.sv
rtl/memReqFsm.sv
rtl/memArbTop.sv
verif/memCtrlModel.sv
verif/memArbTb.sv

// File: Bender.yml
package:
  name: memArb

export_include_dirs:
  - rtl

sources:
  - rtl/memBusPkg.sv
  - rtl/sigTablePkg.sv
  - rtl/sigAddrGen.sv
  - rtl/memReqFsm.sv
  - rtl/memArbTop.sv
  - target: simulation
    files:
      - verif/memCtrlModel.sv
      - verif/memArbTb.sv

// File: verif/memArbTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_config.svh"

module memArbTb;
    import memBusPkg::*;
    import sigTablePkg::*;

    localparam int waitLimit = 400; // negedges per wait
    // masks over respVec
    localparam logic [4:0] instrV = 5'b10000, dataV = 5'b01000, evictV = 5'b00100,
                           accRdV = 5'b00010, accWrV = 5'b00001;

    logic accelWrBlkDone, accelRdBlkDone; // clock, reset
    logic instrCacheBlkReq, dataCacheBlkReq, dataCacheEvictReq, accelDataRd, accelDataWr;
    logic instrBlkValid, dataBlkValid, dataEvictAck, accelRdAck, accelWrAck, transformComplete;
    logic sigTblWr, txDone, rdValid;
    addrT instrAddr, dataAddr, memAddr;
    blkT instrBlk, dataBlk, dataBlk2Mem, accelBlk2Mem, accelBlk2Buffer, memWrData, memRdData;
    sigIdxT sigNum, sigTblIdx;
    chunkNumT sigTblStart, sigTblEnd;
    memOpT memOp;

    logic [4:0] respVec;
    int errCnt;
    addrT busAddr;             // last address seen on the bus
    sigEntryT tblMirror [int]; // what the host loaded
    blkT burstData [4];        // buffer contents for the bursts

    assign respVec = {instrBlkValid, dataBlkValid, dataEvictAck, accelRdAck, accelWrAck};

    memArbTop UUT (.*);
    memCtrlModel memModel (.*);

    always #10 accelWrBlkDone = ~accelWrBlkDone;

    function automatic addrT alignBlk(input addrT a);
        return a & ~((addrT'(1) << `BLK_OFFSET_BITS) - 1); // 64 B blocks
    endfunction

    function automatic addrT chunkAddrOf(input int chunk);
        return `SIG_REGION_BASE + (addrT'(chunk) << `CHUNK_SHIFT);
    endfunction

    task automatic expectEq(input logic [511:0] got, input logic [511:0] exp, input string what);
        assert (got === exp) else begin
            errCnt++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // steps a cycle at a time until one of the masked responses shows
    task automatic waitResp(input logic [4:0] mask, input string what);
        int t;
        t = 0;
        do begin
            @(negedge accelWrBlkDone);
            t++;
            if (memOp != idleOp) begin
                busAddr = memAddr;
            end
        end while ((respVec & mask) == 0 && t < waitLimit);
        if ((respVec & mask) == 0) begin
            $display("timeout: %s never came, %0d errors so far", what, errCnt);
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic loadEntry(input int idx, input int first, input int last);
        sigTblWr = 1'b1;
        sigTblIdx = idx;
        sigTblStart = first;
        sigTblEnd = last;
        tblMirror[idx] = '{endChunk: chunkNumT'(last), startChunk: chunkNumT'(first)};
        @(negedge accelWrBlkDone);
        sigTblWr = 1'b0;
    endtask

    task automatic resetStateTest();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge accelWrBlkDone);
            expectEq(memOp, idleOp, "memOp after reset");
            expectEq({respVec, transformComplete}, '0, "outputs after reset");
        end
    endtask

    task automatic instrReadTest(input addrT a);
        instrAddr = a;
        instrCacheBlkReq = 1'b1;
        waitResp(instrV, "instrBlkValid");
        instrCacheBlkReq = 1'b0; // cache lets go on the valid
        expectEq(busAddr, alignBlk(a), "instr memAddr");
        expectEq(instrBlk, {16{alignBlk(a)}}, "instrBlk");
        @(negedge accelWrBlkDone);
        expectEq(instrBlkValid, 1'b0, "instrBlkValid after the block"); // single pulse
    endtask

    task automatic evictReadTest(input addrT a, input blkT blk);
        dataAddr = a;
        dataBlk2Mem = blk;
        dataCacheEvictReq = 1'b1;
        waitResp(evictV, "dataEvictAck");
        dataCacheEvictReq = 1'b0;
        expectEq(busAddr, alignBlk(a), "evict memAddr");
        dataCacheBlkReq = 1'b1; // read back what was evicted
        waitResp(dataV, "dataBlkValid");
        dataCacheBlkReq = 1'b0;
        expectEq(busAddr, alignBlk(a), "data read memAddr");
        expectEq(dataBlk, blk, "dataBlk after evict");
    endtask

    task automatic priorityTest();
        int k;
        logic [4:0] seen [3];
        loadEntry(3, 20, 20); // single chunk signal
        instrAddr = 32'h0000_0400;
        dataAddr = 32'h0000_0880;
        sigNum = 3;
        {instrCacheBlkReq, dataCacheBlkReq, accelDataWr} = 3'b111; // same cycle
        for (k = 0; k < 3; k++) begin
            waitResp(instrV | dataV | accWrV, "response to the raised requests");
            seen[k] = respVec;
            instrCacheBlkReq = instrCacheBlkReq & ~instrBlkValid;
            dataCacheBlkReq = dataCacheBlkReq & ~dataBlkValid;
            accelDataWr = accelDataWr & ~accelWrAck;
        end
        expectEq(seen[0], accWrV, "first served");
        expectEq(seen[1], dataV, "second served");
        expectEq(seen[2], instrV, "third served");
    endtask

    task automatic accelBurst(input int sig, input bit isWr);
        int i;
        int first;
        int n;
        first = tblMirror[sig].startChunk;
        n = tblMirror[sig].endChunk - first + 1;
        sigNum = sig;
        accelBlk2Mem = burstData[0];
        accelDataWr = isWr;
        accelDataRd = !isWr;
        for (i = 0; i < n; i++) begin
            waitResp(isWr ? accWrV : accRdV, isWr ? "accelWrAck" : "accelRdAck");
            expectEq(busAddr, chunkAddrOf(first + i), "burst memAddr");
            expectEq(transformComplete, i == n - 1, "transformComplete");
            if (!isWr) begin
                expectEq(accelBlk2Buffer, burstData[i], "accelBlk2Buffer");
            end
            accelBlk2Mem = burstData[(i + 1) % n]; // next block before the next edge
            accelDataWr = isWr && i != n - 1;
            accelDataRd = !isWr && i != n - 1;
        end
    endtask

    initial begin
        int i;
        errCnt = 0;
        busAddr = '0;
        accelWrBlkDone = 1'b0;
        accelRdBlkDone = 1'b1;
        {instrCacheBlkReq, dataCacheBlkReq, dataCacheEvictReq} = '0;
        {accelDataRd, accelDataWr, sigTblWr} = '0;
        {instrAddr, dataAddr, dataBlk2Mem, accelBlk2Mem} = '0;
        {sigNum, sigTblIdx, sigTblStart, sigTblEnd} = '0;
        for (i = 0; i < 4; i++) begin
            burstData[i] = {16{32'hacce_0000 + i}};
        end
        repeat (2) @(negedge accelWrBlkDone);
        accelRdBlkDone = 1'b0;

        resetStateTest();
        instrReadTest(32'h0000_1a7c); // inside the 0x1a40 block
        evictReadTest(32'h0000_2367, {8{64'h0123_4567_89ab_cdef}}); // bit 5 set, 0x2340 block
        priorityTest();
        loadEntry(1, 5, 8);
        accelBurst(1, 1'b1);
        accelBurst(1, 1'b0);
        accelBurst(1, 1'b0); // offset must start over at chunk 5

        $display("errors: %0d", errCnt);
        if (errCnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/memCtrlModel.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlModel (
    input  logic             accelWrBlkDone, // clock
    input  logic             accelRdBlkDone, // async reset
    input  memBusPkg::memOpT memOp,
    input  memBusPkg::addrT  memAddr,
    input  memBusPkg::blkT   memWrData,
    output memBusPkg::blkT   memRdData,
    output logic             txDone,
    output logic             rdValid
);
    import memBusPkg::*;

    blkT store [addrT];           // only blocks that were written
    integer seed = 32'h2f93_5879;
    int waitCnt;                  // cycles left in the current phase
    logic busy;                   // command phase running
    logic rdPend;                 // read data still owed
    addrT rdAddr;

    always @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            {txDone, rdValid, busy, rdPend} <= '0;
            waitCnt <= 0;
            rdAddr <= '0;
            memRdData <= '0;
        end else begin
            txDone <= 1'b0;  // single cycle pulses
            rdValid <= 1'b0;
            if (waitCnt != 0) begin
                waitCnt <= waitCnt - 1;
            end else if (rdPend) begin
                rdValid <= 1'b1;
                rdPend <= 1'b0;
                // unwritten block reads back as its own address
                memRdData <= store.exists(rdAddr) ? store[rdAddr] : {16{rdAddr}};
            end else if (busy) begin
                txDone <= 1'b1;
                busy <= 1'b0;
                if (memOp == writeOp) begin
                    store[memAddr] = memWrData;
                end else begin
                    rdPend <= 1'b1;
                    rdAddr <= memAddr;
                    waitCnt <= $unsigned($random(seed)) % 8; // data phase
                end
            end else if (memOp != idleOp && !txDone && !rdValid) begin
                busy <= 1'b1;
                waitCnt <= $unsigned($random(seed)) % 8; // 1 to 8 cycles
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/memArbTop.sv
`timescale 1ns/1ps
`default_nettype none

module memArbTop (
    input  logic                  accelWrBlkDone,    // clock
    input  logic                  accelRdBlkDone,    // async reset, active high
    input  logic                  instrCacheBlkReq,
    input  memBusPkg::addrT       instrAddr,
    output memBusPkg::blkT        instrBlk,
    output logic                  instrBlkValid,
    input  logic                  dataCacheBlkReq,
    input  logic                  dataCacheEvictReq,
    input  memBusPkg::addrT       dataAddr,
    input  memBusPkg::blkT        dataBlk2Mem,
    output memBusPkg::blkT        dataBlk,
    output logic                  dataBlkValid,
    output logic                  dataEvictAck,
    input  logic                  accelDataRd,
    input  logic                  accelDataWr,
    input  sigTablePkg::sigIdxT   sigNum,
    input  memBusPkg::blkT        accelBlk2Mem,
    output memBusPkg::blkT        accelBlk2Buffer,
    output logic                  accelRdAck,
    output logic                  accelWrAck,
    output logic                  transformComplete,
    input  logic                  sigTblWr,          // host table port
    input  sigTablePkg::sigIdxT   sigTblIdx,
    input  sigTablePkg::chunkNumT sigTblStart,
    input  sigTablePkg::chunkNumT sigTblEnd,
    output memBusPkg::memOpT      memOp,             // memory controller port
    output memBusPkg::addrT       memAddr,
    output memBusPkg::blkT        memWrData,
    input  memBusPkg::blkT        memRdData,
    input  logic                  txDone,
    input  logic                  rdValid
);
    import memBusPkg::*;

    addrT chunkAddr;  // current burst chunk
    logic lastChunk;  // burst ends on this chunk
    logic chunkStep;  // advance offset
    logic burstClr;   // rewind offset

    // names match across both blocks
    memReqFsm reqFsm (.*);

    sigAddrGen addrGen (.*);

endmodule

`default_nettype wire

// File: rtl/memReqFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_config.svh"

module memReqFsm (
    input  logic             accelWrBlkDone,    // clock
    input  logic             accelRdBlkDone,    // async reset
    input  logic             instrCacheBlkReq,  // icache miss, level
    input  memBusPkg::addrT  instrAddr,
    output memBusPkg::blkT   instrBlk,
    output logic             instrBlkValid,
    input  logic             dataCacheBlkReq,   // dcache miss, level
    input  logic             dataCacheEvictReq, // dcache evict, level
    input  memBusPkg::addrT  dataAddr,
    input  memBusPkg::blkT   dataBlk2Mem,
    output memBusPkg::blkT   dataBlk,
    output logic             dataBlkValid,
    output logic             dataEvictAck,
    input  logic             accelDataRd,       // buffer fill request
    input  logic             accelDataWr,       // buffer drain request
    input  memBusPkg::blkT   accelBlk2Mem,
    output memBusPkg::blkT   accelBlk2Buffer,
    output logic             accelRdAck,
    output logic             accelWrAck,
    output logic             transformComplete,
    input  memBusPkg::addrT  chunkAddr,         // from sigAddrGen
    input  logic             lastChunk,
    output logic             chunkStep,
    output logic             burstClr,
    output memBusPkg::memOpT memOp,
    output memBusPkg::addrT  memAddr,
    output memBusPkg::blkT   memWrData,
    input  memBusPkg::blkT   memRdData,
    input  logic             txDone,            // command phase over
    input  logic             rdValid            // read data on memRdData
);
    import memBusPkg::*;

    arbStateT currState;
    arbStateT nextState;
    addrT instrAddrAligned;
    addrT dataAddrAligned;
    logic accelReq;
    logic dataReq;

    // caches see 64 B blocks
    assign instrAddrAligned = {instrAddr[`ADDR_WIDTH-1:`BLK_OFFSET_BITS],
                               {`BLK_OFFSET_BITS{1'b0}}};
    assign dataAddrAligned = {dataAddr[`ADDR_WIDTH-1:`BLK_OFFSET_BITS],
                              {`BLK_OFFSET_BITS{1'b0}}};

    assign accelReq = accelDataRd | accelDataWr;
    assign dataReq = dataCacheBlkReq | dataCacheEvictReq;

    // read data fans out, only the valids pick the requester
    assign instrBlk = memRdData;
    assign dataBlk = memRdData;
    assign accelBlk2Buffer = memRdData;

    always_ff @(posedge accelWrBlkDone, posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            currState <= initSt;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState = currState;     // hold while memory is busy
        memOp = idleOp;
        memAddr = '0;
        memWrData = '0;
        instrBlkValid = 1'b0;
        dataBlkValid = 1'b0;
        dataEvictAck = 1'b0;
        accelRdAck = 1'b0;
        accelWrAck = 1'b0;
        transformComplete = 1'b0;
        chunkStep = 1'b0;
        burstClr = 1'b0;

        case (currState)
            initSt: begin
                nextState = idleSt; // table is host loaded, nothing to fetch
            end
            idleSt: begin
                burstClr = accelReq; // accel always wins, so this is its grant
                if (accelReq) begin
                    nextState = accelDataRd ? accelRd : accelWr;
                end else if (dataReq) begin
                    nextState = dataCacheEvictReq ? dataWr : dataRd; // evict first
                end else if (instrCacheBlkReq) begin
                    nextState = instrRd;
                end
            end

            instrRd: begin
                memOp = readOp;
                memAddr = instrAddrAligned;
                if (txDone) begin
                    nextState = instrRdDone;
                end
            end
            instrRdDone: begin
                instrBlkValid = rdValid;
                if (rdValid) begin
                    nextState = idleSt;
                end
            end

            dataRd: begin
                memOp = readOp;
                memAddr = dataAddrAligned;
                if (txDone) begin
                    nextState = dataRdDone;
                end
            end
            dataRdDone: begin
                dataBlkValid = rdValid;
                if (rdValid) begin
                    nextState = idleSt;
                end
            end
            dataWr: begin
                memOp = writeOp;
                memAddr = dataAddrAligned;
                memWrData = dataBlk2Mem; // held until txDone
                if (txDone) begin
                    nextState = dataWrDone;
                end
            end
            dataWrDone: begin
                dataEvictAck = 1'b1;
                nextState = idleSt;
            end

            // buffer fill, one chunk per pass
            accelRd: begin
                memOp = readOp;
                memAddr = chunkAddr;
                if (txDone) begin
                    nextState = accelRdDone;
                end
            end
            accelRdDone: begin
                accelRdAck = rdValid;
                chunkStep = rdValid;
                transformComplete = rdValid & lastChunk;
                if (rdValid) begin
                    nextState = lastChunk ? idleSt : accelRd;
                end
            end

            // buffer drain, next block must be ready by the next edge
            accelWr: begin
                memOp = writeOp;
                memAddr = chunkAddr;
                memWrData = accelBlk2Mem;
                if (txDone) begin
                    nextState = accelWrDone;
                end
            end
            accelWrDone: begin
                accelWrAck = 1'b1;
                chunkStep = 1'b1;
                transformComplete = lastChunk;
                nextState = lastChunk ? idleSt : accelWr;
            end

            default: begin
                nextState = idleSt; // unused codes recover
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/sigAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "memArb_config.svh"

module sigAddrGen (
    input  logic                  accelWrBlkDone, // clock
    input  logic                  accelRdBlkDone, // async reset
    input  logic                  sigTblWr,       // host load strobe
    input  sigTablePkg::sigIdxT   sigTblIdx,
    input  sigTablePkg::chunkNumT sigTblStart,
    input  sigTablePkg::chunkNumT sigTblEnd,
    input  sigTablePkg::sigIdxT   sigNum,         // signal of the running burst
    input  logic                  chunkStep,      // one chunk acked
    input  logic                  burstClr,       // new burst granted
    output memBusPkg::addrT       chunkAddr,
    output logic                  lastChunk
);
    import sigTablePkg::*;

    sigEntryT sigTable [`SIG_TABLE_DEPTH]; // start/end per signal
    sigEntryT curEntry;
    chunkNumT chunkOffset; // chunks done so far in this burst
    chunkNumT curChunk;    // absolute chunk number
    logic [`ADDR_WIDTH-1:0] chunkByteOff;

    // table load from the host side, no reset on storage
    always_ff @(posedge accelWrBlkDone) begin
        if (sigTblWr) begin
            sigTable[sigTblIdx] <= '{endChunk: sigTblEnd, startChunk: sigTblStart};
        end
    end

    // offset walks the burst
    always_ff @(posedge accelWrBlkDone, posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            chunkOffset <= '0;
        end else if (burstClr) begin
            chunkOffset <= '0; // back to the start chunk
        end else if (chunkStep) begin
            chunkOffset <= chunkOffset + 1'b1;
        end
    end

    assign curEntry = sigTable[sigNum];   // sigNum held for the whole burst
    assign curChunk = curEntry.startChunk + chunkOffset;

    // zero extend before the shift, 18 + 11 bits fits the address
    assign chunkByteOff = {{(`ADDR_WIDTH - `CHUNK_WIDTH){1'b0}}, curChunk} << `CHUNK_SHIFT;
    assign chunkAddr = `SIG_REGION_BASE + chunkByteOff;

    // end chunk is inclusive
    assign lastChunk = (curChunk == curEntry.endChunk);

endmodule

`default_nettype wire

// File: rtl/sigTablePkg.sv
`default_nettype none

`include "memArb_config.svh"

package sigTablePkg;

    typedef logic [`CHUNK_WIDTH-1:0] chunkNumT; // chunk index inside the signal region
    typedef logic [`SIG_IDX_WIDTH-1:0] sigIdxT; // signal number, table index

    // end in the upper half, start in the lower
    typedef struct packed {
        chunkNumT endChunk;   // last chunk, inclusive
        chunkNumT startChunk; // first chunk of the burst
    } sigEntryT;

endpackage

`default_nettype wire

// File: rtl/memBusPkg.sv
`default_nettype none

`include "memArb_config.svh"

package memBusPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT; // byte address on the mc port
    typedef logic [`BLK_WIDTH-1:0] blkT;   // one block, any requester

    // op code as the memory controller decodes it
    typedef enum logic [1:0] {
        idleOp  = 2'b00,
        readOp  = 2'b01,
        writeOp = 2'b11
    } memOpT;

    // request fsm, each bus state paired with its done state
    typedef enum logic [3:0] {
        initSt      = 4'b0000,
        idleSt      = 4'b0001,
        instrRd     = 4'b0010,
        instrRdDone = 4'b0011,
        dataRd      = 4'b0100,
        dataRdDone  = 4'b0101,
        dataWr      = 4'b0110,
        dataWrDone  = 4'b0111,
        accelRd     = 4'b1000,
        accelRdDone = 4'b1001,
        accelWr     = 4'b1010,
        accelWrDone = 4'b1011
    } arbStateT;

endpackage

`default_nettype wire

// File: rtl/memArb_config.svh
`ifndef MEMARB_CONFIG_SVH
`define MEMARB_CONFIG_SVH

// memory controller port
`define BLK_WIDTH 512        // one block per transfer
`define ADDR_WIDTH 32        // byte address
`define BLK_OFFSET_BITS 6    // 64 B blocks, low bits dropped on cache addresses

// signal table geometry
`define CHUNK_WIDTH 18       // chunk number
`define SIG_IDX_WIDTH 13     // signal number
`define SIG_TABLE_DEPTH 8192 // one entry per signal

// signal region in host memory
`define SIG_REGION_BASE 32'h1000_0000
`define CHUNK_SHIFT 11       // chunk stride is 2 KB

`endif
